// ==== Bender.yml ====
package:
  name: sl_support

sources:
  - files:
      - design/sl_pkg.sv
      - design/sl_trigger_regs.sv
      - design/sl_trigger_match.sv
      - design/sl_obi_phase_monitor.sv
      - design/sl_obi_attr_tracker.sv
      - design/sl_support_top.sv
  - target: test
    files:
      - test/tb_sl_support.sv

// ==== design/sl_obi_attr_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sl_obi_attr_tracker (
  input  logic              in_support_if,
  input  logic              arst_n_i,
  input  sl_pkg::obi_bus_t  obi_i,
  input  logic              req_is_store_i,
  output sl_pkg::obi_attr_t resp_attr_o
);

  logic                       gntpar_err;
  logic                       gntpar_err_q;
  logic                       push;
  logic                       pop;
  logic                       full;
  logic [sl_pkg::QPTR_W-1:0]  wr_ptr_q;
  logic [sl_pkg::QPTR_W-1:0]  rd_ptr_q;
  logic [sl_pkg::OUTST_W-1:0] fill_q;
  sl_pkg::obi_attr_t          queue_q [sl_pkg::OBI_MAX_OUTSTANDING];

  // --------------------------------------------------
  // grant parity error
  // --------------------------------------------------

  // gntpar must be the inverse of gnt, an earlier error sticks until granted
  assign gntpar_err = obi_i.req && ((obi_i.gnt == obi_i.gntpar) || gntpar_err_q);

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gntpar_err_q <= 1'b0;
    end else if (obi_i.req && !obi_i.gnt) begin
      gntpar_err_q <= gntpar_err;
    end else begin
      gntpar_err_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // in-order attribute queue
  // --------------------------------------------------

  assign full = (int'(fill_q) == sl_pkg::OBI_MAX_OUTSTANDING);
  assign push = obi_i.req && obi_i.gnt;
  assign pop  = obi_i.rvalid && (fill_q != '0);

  always_ff @(posedge in_support_if) begin
    if (push) begin
      queue_q[wr_ptr_q] <= '{is_store: req_is_store_i, gntpar_err: gntpar_err};
    end
  end

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop && !push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // head entry belongs to the response seen this cycle
  assign resp_attr_o = pop ? queue_q[rd_ptr_q] : '0;

  // a grant on a full queue is only legal when a response frees a slot
  a_no_push_full: assert property (
    @(posedge in_support_if) disable iff (!arst_n_i)
    (push && full) |-> pop
  ) else $error("attribute queue overflow");

endmodule : sl_obi_attr_tracker

`default_nettype wire

// ==== design/sl_obi_phase_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module sl_obi_phase_monitor (
  input  logic                in_support_if,
  input  logic                arst_n_i,
  input  sl_pkg::obi_bus_t    obi_i,
  output sl_pkg::obi_status_t status_o
);

  logic                       addr_done;
  logic [sl_pkg::OUTST_W-1:0] cnt_q;
  logic [sl_pkg::OUTST_W-1:0] cnt_d;
  logic                       addr_ph_cont_q;
  logic                       resp_ph_cont_q;

  assign addr_done = obi_i.req && obi_i.gnt;

  // grant and response in one cycle leave the count as is
  always_comb begin
    cnt_d = cnt_q;
    if (addr_done && !obi_i.rvalid) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!addr_done && obi_i.rvalid) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q          <= '0;
      addr_ph_cont_q <= 1'b0;
      resp_ph_cont_q <= 1'b0;
    end else begin
      cnt_q          <= cnt_d;
      // request still waiting for its grant
      addr_ph_cont_q <= obi_i.req && !obi_i.gnt;
      resp_ph_cont_q <= (cnt_d != '0);
    end
  end

  assign status_o.addr_ph_cont  = addr_ph_cont_q;
  assign status_o.resp_ph_cont  = resp_ph_cont_q;
  assign status_o.v_addr_ph_cnt = cnt_q;

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------

  a_no_orphan_rvalid: assert property (
    @(posedge in_support_if) disable iff (!arst_n_i)
    obi_i.rvalid |-> (cnt_q != '0)
  ) else $error("rvalid with no outstanding request");

  a_cnt_bound: assert property (
    @(posedge in_support_if) disable iff (!arst_n_i)
    int'(cnt_q) <= sl_pkg::OBI_MAX_OUTSTANDING
  ) else $error("outstanding count %0d above limit", cnt_q);

endmodule : sl_obi_phase_monitor

`default_nettype wire

// ==== design/sl_pkg.sv ====
`default_nettype none

package sl_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------

  localparam int XLEN                = 32;
  localparam int NUM_TRIGGERS        = 4;
  localparam int TSEL_W              = 2;
  localparam int MEM_BYTES           = 4;
  localparam int OBI_MAX_OUTSTANDING = 4;
  localparam int OUTST_W             = 3;
  // index width of the attribute queue
  localparam int QPTR_W              = $clog2(OBI_MAX_OUTSTANDING);

  // --------------------------------------------------
  // tdata1 layout
  // --------------------------------------------------

  // type 15 with dmode set, i.e. a disabled trigger
  localparam logic [XLEN-1:0] TDATA1_DEFAULT = 32'hF800_0000;

  localparam int TDATA1_LOAD      = 0;
  localparam int TDATA1_STORE     = 1;
  localparam int TDATA1_EXECUTE   = 2;
  localparam int TDATA1_U_MODE    = 3;
  localparam int TDATA1_M_MODE    = 6;
  localparam int TDATA1_MATCH_LSB = 7;
  localparam int TDATA1_MATCH_MSB = 10;
  localparam int TDATA1_TYPE_LSB  = 28;
  localparam int TDATA1_TYPE_MSB  = 31;

  typedef enum logic [3:0] {
    TRIG_MCONTROL  = 4'd2,
    TRIG_MCONTROL6 = 4'd6,
    TRIG_DISABLED  = 4'd15
  } trig_type_e;

  typedef enum logic [3:0] {
    MATCH_EQ = 4'd0,
    MATCH_GE = 4'd2,
    MATCH_LT = 4'd3
  } match_mode_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_e;

  // --------------------------------------------------
  // bundles
  // --------------------------------------------------

  // one retired instruction with a single memory access
  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      mem_addr;
    logic [MEM_BYTES-1:0] rmask;
    logic [MEM_BYTES-1:0] wmask;
    priv_e                priv;
  } retire_t;

  typedef struct packed {
    logic              valid;
    logic [TSEL_W-1:0] sel;
    logic [XLEN-1:0]   tdata1;
    logic [XLEN-1:0]   tdata2;
  } tdata_wr_t;

  typedef struct packed {
    logic [XLEN-1:0] tdata1;
    logic [XLEN-1:0] tdata2;
  } trig_cfg_t;

  typedef struct packed {
    logic [NUM_TRIGGERS-1:0] execute;
    logic [NUM_TRIGGERS-1:0] load;
    logic [NUM_TRIGGERS-1:0] store;
    logic                    any_execute;
    logic                    any_load;
    logic                    any_store;
  } trig_match_t;

  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    logic gntpar;
  } obi_bus_t;

  typedef struct packed {
    logic               addr_ph_cont;
    logic               resp_ph_cont;
    logic [OUTST_W-1:0] v_addr_ph_cnt;
  } obi_status_t;

  typedef struct packed {
    logic is_store;
    logic gntpar_err;
  } obi_attr_t;

endpackage : sl_pkg

`default_nettype wire

// ==== design/sl_support_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sl_support_top (
  input  logic                in_support_if,
  input  logic                arst_n_i,
  input  sl_pkg::retire_t     retire_i,
  input  sl_pkg::tdata_wr_t   tdata_wr_i,
  input  sl_pkg::obi_bus_t    data_obi_i,
  input  logic                req_is_store_i,
  output sl_pkg::trig_match_t trig_match_o,
  output sl_pkg::obi_status_t data_obi_status_o,
  output sl_pkg::obi_attr_t   resp_attr_o
);

  // --------------------------------------------------
  // debug triggers
  // --------------------------------------------------

  sl_pkg::trig_cfg_t [sl_pkg::NUM_TRIGGERS-1:0] trig_cfg;

  sl_trigger_regs u_trigger_regs (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .tdata_wr_i    (tdata_wr_i),
    .trig_cfg_o    (trig_cfg)
  );

  sl_trigger_match u_trigger_match (
    .in_support_if (in_support_if),
    .retire_i      (retire_i),
    .trig_cfg_i    (trig_cfg),
    .trig_match_o  (trig_match_o)
  );

  // --------------------------------------------------
  // obi data bus
  // --------------------------------------------------

  // phase tracking
  sl_obi_phase_monitor u_data_phase_monitor (
    .in_support_if (in_support_if),
    .arst_n_i      (arst_n_i),
    .obi_i         (data_obi_i),
    .status_o      (data_obi_status_o)
  );

  // store flag and grant parity error per response
  sl_obi_attr_tracker u_data_attr_tracker (
    .in_support_if  (in_support_if),
    .arst_n_i       (arst_n_i),
    .obi_i          (data_obi_i),
    .req_is_store_i (req_is_store_i),
    .resp_attr_o    (resp_attr_o)
  );

endmodule : sl_support_top

`default_nettype wire

// ==== design/sl_trigger_match.sv ====
`timescale 1ns/1ps
`default_nettype none

module sl_trigger_match (
  // only samples the assertions below
  input  logic                                          in_support_if,
  input  sl_pkg::retire_t                               retire_i,
  input  sl_pkg::trig_cfg_t [sl_pkg::NUM_TRIGGERS-1:0] trig_cfg_i,
  output sl_pkg::trig_match_t                           trig_match_o
);

  // address compare for the three supported match modes
  function automatic logic addr_hit(input logic [sl_pkg::XLEN-1:0] addr,
                                    input logic [sl_pkg::XLEN-1:0] tdata2,
                                    input logic [3:0]              mode);
    logic hit;
    case (mode)
      sl_pkg::MATCH_EQ: hit = (addr == tdata2);
      sl_pkg::MATCH_GE: hit = (addr >= tdata2);
      sl_pkg::MATCH_LT: hit = (addr < tdata2);
      default:          hit = 1'b0;
    endcase
    return hit;
  endfunction

  logic [sl_pkg::NUM_TRIGGERS-1:0]                        eligible;
  logic [sl_pkg::NUM_TRIGGERS-1:0]                        exec_hit;
  logic [sl_pkg::NUM_TRIGGERS-1:0]                        load_hit;
  logic [sl_pkg::NUM_TRIGGERS-1:0]                        store_hit;
  logic [sl_pkg::NUM_TRIGGERS-1:0][sl_pkg::MEM_BYTES-1:0] byte_hit;
  logic                                                   any_exec;

  for (genvar t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin : g_trig
    logic [3:0] ttype;
    logic [3:0] mode;
    logic       priv_en;

    assign ttype = trig_cfg_i[t].tdata1[sl_pkg::TDATA1_TYPE_MSB:sl_pkg::TDATA1_TYPE_LSB];
    assign mode  = trig_cfg_i[t].tdata1[sl_pkg::TDATA1_MATCH_MSB:sl_pkg::TDATA1_MATCH_LSB];

    // privilege enable bit for the mode the instruction retired in
    assign priv_en =
      (retire_i.priv == sl_pkg::PRIV_M && trig_cfg_i[t].tdata1[sl_pkg::TDATA1_M_MODE]) ||
      (retire_i.priv == sl_pkg::PRIV_U && trig_cfg_i[t].tdata1[sl_pkg::TDATA1_U_MODE]);

    assign eligible[t] = retire_i.valid && priv_en &&
                         (ttype == sl_pkg::TRIG_MCONTROL || ttype == sl_pkg::TRIG_MCONTROL6);

    assign exec_hit[t] = eligible[t] && trig_cfg_i[t].tdata1[sl_pkg::TDATA1_EXECUTE] &&
                         addr_hit(retire_i.pc, trig_cfg_i[t].tdata2, mode);

    // every byte of the access is compared on its own
    for (genvar i = 0; i < sl_pkg::MEM_BYTES; i++) begin : g_byte
      logic [sl_pkg::XLEN-1:0] byte_addr;

      assign byte_addr      = retire_i.mem_addr + i;
      assign byte_hit[t][i] = addr_hit(byte_addr, trig_cfg_i[t].tdata2, mode);
    end

    // data triggers are masked whenever any execute trigger fires
    assign load_hit[t] = eligible[t] && !any_exec &&
                         trig_cfg_i[t].tdata1[sl_pkg::TDATA1_LOAD] &&
                         |(retire_i.rmask & byte_hit[t]);

    assign store_hit[t] = eligible[t] && !any_exec &&
                          trig_cfg_i[t].tdata1[sl_pkg::TDATA1_STORE] &&
                          |(retire_i.wmask & byte_hit[t]);
  end

  assign any_exec = |exec_hit;

  assign trig_match_o.execute     = exec_hit;
  assign trig_match_o.load        = load_hit;
  assign trig_match_o.store       = store_hit;
  assign trig_match_o.any_execute = any_exec;
  assign trig_match_o.any_load    = |load_hit;
  assign trig_match_o.any_store   = |store_hit;

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------

  a_any_exec: assert property (
    @(posedge in_support_if)
    trig_match_o.any_execute == |trig_match_o.execute
  ) else $error("any_execute disagrees with execute vector");

endmodule : sl_trigger_match

`default_nettype wire

// ==== design/sl_trigger_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sl_trigger_regs (
  input  logic                                          in_support_if,
  input  logic                                          arst_n_i,
  input  sl_pkg::tdata_wr_t                             tdata_wr_i,
  output sl_pkg::trig_cfg_t [sl_pkg::NUM_TRIGGERS-1:0] trig_cfg_o
);

  sl_pkg::trig_cfg_t [sl_pkg::NUM_TRIGGERS-1:0] cfg_q;

  // all triggers come out of reset disabled with a zero compare value
  always_ff @(posedge in_support_if or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin
        cfg_q[t].tdata1 <= sl_pkg::TDATA1_DEFAULT;
        cfg_q[t].tdata2 <= '0;
      end
    end else if (tdata_wr_i.valid) begin
      cfg_q[tdata_wr_i.sel].tdata1 <= tdata_wr_i.tdata1;
      cfg_q[tdata_wr_i.sel].tdata2 <= tdata_wr_i.tdata2;
    end
  end

  // new values reach the match logic from the next cycle on
  assign trig_cfg_o = cfg_q;

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------

  // software may only select implemented triggers
  a_sel_in_range: assert property (
    @(posedge in_support_if) disable iff (!arst_n_i)
    tdata_wr_i.valid |-> (int'(tdata_wr_i.sel) < sl_pkg::NUM_TRIGGERS)
  ) else $error("trigger write selects unimplemented trigger %0d", tdata_wr_i.sel);

endmodule : sl_trigger_regs

`default_nettype wire

// ==== flist.f ====
design/sl_pkg.sv
design/sl_trigger_regs.sv
design/sl_trigger_match.sv
design/sl_obi_phase_monitor.sv
design/sl_obi_attr_tracker.sv
design/sl_support_top.sv
test/tb_sl_support.sv

// ==== test/tb_sl_support.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sl_support;

  localparam int              RESET_CYCLES = 2;
  localparam int              IDLE_CYCLES  = 20;
  localparam int              NUM_CYCLES   = 3000;
  localparam int              TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 10) * 10 + 500;
  // pc, data address and tdata2 all land in one 64-byte window
  localparam logic [31:0]     ADDR_BASE    = 32'h8000_0100;

  logic                clk;
  logic                arst_n;
  sl_pkg::retire_t     retire;
  sl_pkg::tdata_wr_t   tdata_wr;
  sl_pkg::obi_bus_t    data_obi;
  logic                req_is_store;
  sl_pkg::trig_match_t dut_match;
  sl_pkg::obi_status_t dut_status;
  sl_pkg::obi_attr_t   resp_attr;

  // reference state, advanced at each falling edge
  sl_pkg::trig_cfg_t cfg_model [sl_pkg::NUM_TRIGGERS];
  sl_pkg::obi_attr_t attr_q [$];
  int                cnt_m;
  logic              addr_cont_m;
  logic              resp_cont_m;
  logic              err_latch_m;
  int                err_cnt;
  logic [31:0]       rng_state;

  sl_support_top dut0 (
    .in_support_if     (clk),
    .arst_n_i          (arst_n),
    .retire_i          (retire),
    .tdata_wr_i        (tdata_wr),
    .data_obi_i        (data_obi),
    .req_is_store_i    (req_is_store),
    .trig_match_o      (dut_match),
    .data_obi_status_o (dut_status),
    .resp_attr_o       (resp_attr)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_on_failure(input string why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      stop_on_failure("output value mismatch");
    end
  endtask

  // unknown match values never hit
  function automatic logic addr_matches(input logic [31:0] addr, input logic [31:0] cmp,
                                        input logic [3:0] mode);
    if (mode == sl_pkg::MATCH_EQ) return addr == cmp;
    if (mode == sl_pkg::MATCH_GE) return addr >= cmp;
    if (mode == sl_pkg::MATCH_LT) return addr < cmp;
    return 1'b0;
  endfunction

  function automatic sl_pkg::trig_match_t ref_match(input sl_pkg::retire_t r);
    sl_pkg::trig_match_t             m;
    logic [sl_pkg::NUM_TRIGGERS-1:0] ok;
    logic [31:0]                     t1;
    logic [3:0]                      mode;
    m = '0;
    for (int t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin
      t1    = cfg_model[t].tdata1;
      ok[t] = r.valid &&
              (t1[31:28] == sl_pkg::TRIG_MCONTROL || t1[31:28] == sl_pkg::TRIG_MCONTROL6) &&
              ((r.priv == sl_pkg::PRIV_M && t1[sl_pkg::TDATA1_M_MODE]) ||
               (r.priv == sl_pkg::PRIV_U && t1[sl_pkg::TDATA1_U_MODE]));
      m.execute[t] = ok[t] && t1[sl_pkg::TDATA1_EXECUTE] &&
                     addr_matches(r.pc, cfg_model[t].tdata2, t1[10:7]);
    end
    m.any_execute = |m.execute;
    for (int t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin
      t1   = cfg_model[t].tdata1;
      mode = t1[10:7];
      for (int i = 0; i < sl_pkg::MEM_BYTES; i++) begin
        if (ok[t] && !m.any_execute &&
            addr_matches(r.mem_addr + i, cfg_model[t].tdata2, mode)) begin
          if (r.rmask[i] && t1[sl_pkg::TDATA1_LOAD]) m.load[t] = 1'b1;
          if (r.wmask[i] && t1[sl_pkg::TDATA1_STORE]) m.store[t] = 1'b1;
        end
      end
    end
    m.any_load  = |m.load;
    m.any_store = |m.store;
    return m;
  endfunction

  // mostly legal types and modes, now and then an unknown one
  function automatic logic [31:0] random_tdata1();
    logic [31:0] t1;
    logic [31:0] r;
    t1 = next_rand();
    r  = next_rand();
    case (r[1:0])
      2'd0:    t1[31:28] = sl_pkg::TRIG_MCONTROL;
      2'd1:    t1[31:28] = sl_pkg::TRIG_MCONTROL6;
      2'd2:    t1[31:28] = sl_pkg::TRIG_DISABLED;
      default: t1[31:28] = r[5:2];
    endcase
    case (r[7:6])
      2'd0:    t1[10:7] = sl_pkg::MATCH_EQ;
      2'd1:    t1[10:7] = sl_pkg::MATCH_GE;
      2'd2:    t1[10:7] = sl_pkg::MATCH_LT;
      default: t1[10:7] = r[11:8];
    endcase
    return t1;
  endfunction

  task automatic reset_models();
    for (int t = 0; t < sl_pkg::NUM_TRIGGERS; t++) begin
      cfg_model[t] = '{tdata1: sl_pkg::TDATA1_DEFAULT, tdata2: 32'h0};
    end
    attr_q.delete();
    cnt_m       = 0;
    addr_cont_m = 1'b0;
    resp_cont_m = 1'b0;
    err_latch_m = 1'b0;
  endtask

  // --------------------------------------------------
  // clock, watchdog and compare process
  // --------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    stop_on_failure("watchdog expired before the test sequence finished");
  end

  // outputs are stable at the falling edge
  initial begin : compare_proc
    sl_pkg::obi_attr_t exp_attr;
    sl_pkg::obi_attr_t new_attr;
    logic              err_now;
    forever begin
      @(negedge clk);
      if (!arst_n) begin
        reset_models();
      end else begin
        check_eq(dut_match, ref_match(retire), "trigger match vector");
        check_eq(dut_status.v_addr_ph_cnt, cnt_m, "outstanding count");
        check_eq(dut_status.addr_ph_cont, addr_cont_m, "address phase continuation");
        check_eq(dut_status.resp_ph_cont, resp_cont_m, "response phase continuation");
        exp_attr = '0;
        if (data_obi.rvalid && attr_q.size() > 0) exp_attr = attr_q[0];
        check_eq(resp_attr, exp_attr, "response attributes");
        // advance the models to what the next rising edge stores
        err_now = data_obi.req && ((data_obi.gnt == data_obi.gntpar) || err_latch_m);
        err_latch_m = data_obi.req && !data_obi.gnt && err_now;
        if (data_obi.rvalid && attr_q.size() > 0) void'(attr_q.pop_front());
        if (data_obi.req && data_obi.gnt) begin
          new_attr.is_store   = req_is_store;
          new_attr.gntpar_err = err_now;
          attr_q.push_back(new_attr);
        end
        cnt_m       = cnt_m + int'(data_obi.req && data_obi.gnt) - int'(data_obi.rvalid);
        addr_cont_m = data_obi.req && !data_obi.gnt;
        resp_cont_m = (cnt_m != 0);
        if (tdata_wr.valid) begin
          cfg_model[tdata_wr.sel] = '{tdata1: tdata_wr.tdata1, tdata2: tdata_wr.tdata2};
        end
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin : driver
    sl_pkg::retire_t   ret;
    sl_pkg::tdata_wr_t wr;
    sl_pkg::obi_bus_t  bus;
    logic [31:0]       r;
    logic              req_hold;
    int                outst;
    rng_state    = 32'hd2c9ddf1;
    err_cnt      = 0;
    arst_n       = 1'b0;
    retire       = '0;
    tdata_wr     = '0;
    data_obi     = '0;
    req_is_store = 1'b0;
    req_hold     = 1'b0;
    outst        = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      r            = next_rand();
      ret.valid    = r[0] | r[1];
      ret.priv     = r[2] ? sl_pkg::PRIV_M : sl_pkg::PRIV_U;
      ret.rmask    = r[7:4];
      ret.wmask    = r[11:8];
      ret.pc       = ADDR_BASE + (next_rand() & 32'h3F);
      ret.mem_addr = ADDR_BASE + (next_rand() & 32'h3F);
      wr.valid     = (cyc >= IDLE_CYCLES) && (r[13:12] == 2'b00);
      wr.sel       = r[15:14];
      wr.tdata1    = random_tdata1();
      wr.tdata2    = ADDR_BASE + (next_rand() & 32'h3F);
      bus          = '0;
      if (cyc >= IDLE_CYCLES) begin
        // a request stays up until it is granted
        bus.req    = req_hold | r[16];
        bus.gnt    = (outst < sl_pkg::OBI_MAX_OUTSTANDING) && (r[17] | r[18]);
        bus.rvalid = (outst > 0) && r[19];
        // occasional parity error on the grant
        bus.gntpar = (r[22:20] == 3'd0) ? bus.gnt : !bus.gnt;
        req_hold   = bus.req && !bus.gnt;
        outst      = outst + int'(bus.req && bus.gnt) - int'(bus.rvalid);
      end
      retire       <= ret;
      tdata_wr     <= wr;
      data_obi     <= bus;
      req_is_store <= r[23];
    end
    @(posedge clk);
    tdata_wr <= '0;
    data_obi <= '0;
    repeat (3) @(posedge clk);
    if (err_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_on_failure("checks failed during the run");
    end
  end

endmodule : tb_sl_support

`default_nettype wire
